// File: run_sim.sh
#!/bin/sh
# Build and run the data cache hit stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_dcache_hit \
  --Mdir obj_dir \
  -o sim_tb

# Keep the log even when the run stops early
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  echo "Run did not report a pass, see sim.log"
  exit 1
fi

// File: source/dcache_hit_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_hit_top #(
  parameter  int INFLIGHT_DEPTH = 2,
  localparam int INFLIGHT_BITS  = $clog2(INFLIGHT_DEPTH+1)
)
(
  input  wire                        clk_i,
  input  wire                        rst_ni,

  // Core side
  input  wire                        req_i,
  input  wire                        wreq_i,
  input  wire                        flush_i,
  input  dcache_pkg::core_req_t      core_req_i,
  output logic                       stall_o,
  output logic                       ack_o,
  output dcache_pkg::data_t          q_o,

  // Status
  output logic                       armed_o,
  output logic                       filling_o,

  // Tag/data memories
  input  dcache_pkg::lookup_t        lookup_i,
  output dcache_pkg::idx_t           idx_o,
  output dcache_pkg::tag_t           core_tag_o,

  // Write buffer
  output logic                       wb_valid_o,
  output dcache_pkg::wb_entry_t      wb_entry_o,
  input  wire                        writebuffer_ack_i,

  // Evict buffer
  output dcache_pkg::evict_t         evict_o,

  // Bus interface
  input  dcache_pkg::biu_rsp_t       biu_rsp_i,
  input  wire [INFLIGHT_BITS   -1:0] inflight_cnt_i,
  output dcache_pkg::biucmd_e        biucmd_o,
  output logic                       biucmd_noncacheable_req_o
);

  // Read select hint from the FSM
  logic fill_pending;

  ////////////////////////////////////////////////////////////
  // Address slicing for the memory access
  ////////////////////////////////////////////////////////////

  // Set index sits right above the block offset
  assign idx_o = core_req_i.adr[dcache_pkg::BLK_OFFS_BITS +: dcache_pkg::IDX_BITS];

  // Tag is the upper part of the address
  assign core_tag_o = core_req_i.adr[dcache_pkg::PLEN-1 -: dcache_pkg::TAG_BITS];

  ////////////////////////////////////////////////////////////
  // Sub blocks
  ////////////////////////////////////////////////////////////

  // Memory FSM, stall/ack and bus commands
  dcache_miss_ctrl #(
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
  ) u_miss_ctrl (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .req_i                     (req_i),
    .flush_i                   (flush_i),
    .core_req_i                (core_req_i),
    .lookup_i                  (lookup_i),
    .biu_rsp_i                 (biu_rsp_i),
    .inflight_cnt_i            (inflight_cnt_i),
    .idx_i                     (idx_o),
    .stall_o                   (stall_o),
    .ack_o                     (ack_o),
    .armed_o                   (armed_o),
    .filling_o                 (filling_o),
    .fill_pending_o            (fill_pending),
    .biucmd_o                  (biucmd_o),
    .biucmd_noncacheable_req_o (biucmd_noncacheable_req_o),
    .evict_o                   (evict_o)
  );

  // Write hit capture
  dcache_write_capture u_write_capture (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .wreq_i            (wreq_i),
    .flush_i           (flush_i),
    .core_req_i        (core_req_i),
    .lookup_i          (lookup_i),
    .writebuffer_ack_i (writebuffer_ack_i),
    .wb_valid_o        (wb_valid_o),
    .wb_entry_o        (wb_entry_o)
  );

  // Read data path
  dcache_read_mux u_read_mux (
    .clk_i          (clk_i),
    .core_req_i     (core_req_i),
    .lookup_i       (lookup_i),
    .biu_rsp_i      (biu_rsp_i),
    .fill_pending_i (fill_pending),
    .q_o            (q_o)
  );

endmodule

`default_nettype wire

// File: source/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl #(
  parameter  int INFLIGHT_DEPTH = 2,
  localparam int INFLIGHT_BITS  = $clog2(INFLIGHT_DEPTH+1)
)
(
  input  wire                        clk_i,
  input  wire                        rst_ni,

  input  wire                        req_i,
  input  wire                        flush_i,
  input  dcache_pkg::core_req_t      core_req_i,
  input  dcache_pkg::lookup_t        lookup_i,
  input  dcache_pkg::biu_rsp_t       biu_rsp_i,
  input  wire [INFLIGHT_BITS   -1:0] inflight_cnt_i,
  input  dcache_pkg::idx_t           idx_i,

  output logic                       stall_o,
  output logic                       ack_o,
  output logic                       armed_o,
  output logic                       filling_o,
  output logic                       fill_pending_o,
  output dcache_pkg::biucmd_e        biucmd_o,
  output logic                       biucmd_noncacheable_req_o,
  output dcache_pkg::evict_t         evict_o
);

  // Lowest address bit above the byte lanes
  localparam int WORD_LSB = $clog2(dcache_pkg::XLEN/8);

  // Memory interface states
  typedef enum logic [2:0] {
    ST_ARMED,
    ST_NONCACHEABLE,
    ST_EVICT,
    ST_WAIT_FILL,
    ST_RECOVER
  } state_e;

  state_e state;

  logic biu_adr_match;
  logic cache_ack;
  logic biu_cacheable_ack;
  logic cacheable_miss;

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////

  // Returned bus word is the requested word
  assign biu_adr_match = biu_rsp_i.adro[dcache_pkg::PLEN-1:WORD_LSB] ==
                         core_req_i.adr[dcache_pkg::PLEN-1:WORD_LSB];

  // Plain hit, served from the line
  assign cache_ack = req_i & core_req_i.cacheable & lookup_i.hit & ~flush_i;

  // Hit, or the wanted word passing by on the bus
  assign biu_cacheable_ack = (req_i & biu_rsp_i.ack & biu_adr_match & ~flush_i) | cache_ack;

  assign cacheable_miss = req_i & core_req_i.cacheable & ~lookup_i.hit & ~flush_i;

  ////////////////////////////////////////////////////////////
  // Memory FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state     <= ST_ARMED;
      armed_o   <= 1'b1;
      filling_o <= 1'b0;
      biucmd_o  <= dcache_pkg::NOP;
    end
    else
    begin
      unique case (state)
        ST_ARMED:
          if (req_i && !core_req_i.cacheable && !flush_i)
          begin
            state   <= ST_NONCACHEABLE;
            armed_o <= 1'b0;
          end
          else if (cacheable_miss && !biu_rsp_i.busy)
          begin
            // Dirty victim still fetches the new line first
            state     <= lookup_i.way_dirty ? ST_EVICT : ST_WAIT_FILL;
            biucmd_o  <= dcache_pkg::READWAY;
            armed_o   <= 1'b0;
            filling_o <= 1'b1;
          end
          else
          begin
            biucmd_o <= dcache_pkg::NOP;
          end

        ST_NONCACHEABLE:
          // Pipe flushed, last beat done, or cacheable request waiting
          if (flush_i ||
              (!req_i && inflight_cnt_i == INFLIGHT_BITS'(1) && biu_rsp_i.ack) ||
              (req_i && core_req_i.cacheable && biu_rsp_i.ack))
          begin
            state   <= ST_ARMED;
            armed_o <= 1'b1;
          end

        ST_EVICT:
          if (biu_rsp_i.cmd_ack)
          begin
            // Fill done, now write the old line back
            state     <= ST_RECOVER;
            biucmd_o  <= dcache_pkg::WRITEWAY;
            filling_o <= 1'b0;
          end

        ST_WAIT_FILL:
          if (biu_rsp_i.cmd_ack)
          begin
            state     <= ST_RECOVER;
            biucmd_o  <= dcache_pkg::NOP;
            filling_o <= 1'b0;
          end

        ST_RECOVER:
        begin
          // One cycle for the memories to present the new line
          state    <= ST_ARMED;
          biucmd_o <= dcache_pkg::NOP;
          armed_o  <= 1'b1;
        end

        default:
        begin
          state     <= ST_ARMED;
          armed_o   <= 1'b1;
          filling_o <= 1'b0;
          biucmd_o  <= dcache_pkg::NOP;
        end
      endcase
    end
  end

  // Read mux picks bus data while waiting for a fill
  assign fill_pending_o = (state == ST_WAIT_FILL);

  ////////////////////////////////////////////////////////////
  // Evict buffer
  ////////////////////////////////////////////////////////////

  // Victim line tracks the lookup until the FSM leaves armed
  always_ff @(posedge clk_i)
  begin
    if (state == ST_ARMED)
    begin
      evict_o.adr  <= {lookup_i.vtag, idx_i, {dcache_pkg::BLK_OFFS_BITS{1'b0}}};
      evict_o.line <= lookup_i.line;
    end
  end

  // Uncached request goes straight out while armed
  assign biucmd_noncacheable_req_o = (state == ST_ARMED) & req_i &
                                     ~core_req_i.cacheable & ~flush_i;

  ////////////////////////////////////////////////////////////
  // Stall and acknowledge
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    unique case (state)
      ST_ARMED:
        stall_o = (req_i & ~core_req_i.cacheable & (~biu_rsp_i.stb_ack | biu_rsp_i.busy)) |
                  (req_i &  core_req_i.cacheable & ~lookup_i.hit);
      // Idle waits for beats, cacheable waits for the end of the transfer
      ST_NONCACHEABLE:
        stall_o = ~req_i ? |inflight_cnt_i
                         : (core_req_i.cacheable ? ~biu_rsp_i.ack : ~biu_rsp_i.stb_ack);
      ST_EVICT,
      ST_WAIT_FILL:
        stall_o = ~(biu_cacheable_ack | (req_i & lookup_i.hit));
      ST_RECOVER:
        stall_o = ~(req_i & lookup_i.hit);
      default:
        stall_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      ack_o <= 1'b0;
    else
    begin
      unique case (state)
        ST_ARMED:        ack_o <= cache_ack;
        ST_NONCACHEABLE: ack_o <= biu_rsp_i.nc_ack;
        ST_EVICT:        ack_o <= biu_cacheable_ack;
        ST_WAIT_FILL:    ack_o <= biu_cacheable_ack;
        ST_RECOVER:      ack_o <= cache_ack;
        default:         ack_o <= 1'b0;
      endcase
    end
  end

  // Write-back only after the fill, never during it
  a_no_writeway_in_fill: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state == ST_WAIT_FILL |-> biucmd_o != dcache_pkg::WRITEWAY
  );

  // Fill flag matches the line transfer states
  a_filling_states: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    filling_o |-> state inside {ST_EVICT, ST_WAIT_FILL}
  );

endmodule

`default_nettype wire

// File: source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  ////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////

  // 32-bit core, 16-byte blocks, 2 ways, 32 sets
  localparam int XLEN          = 32;
  localparam int PLEN          = 32;
  localparam int WAYS          = 2;
  localparam int BLK_BITS      = 128;
  localparam int BLK_OFFS_BITS = 4;
  localparam int DAT_OFFS_BITS = 2;
  localparam int IDX_BITS      = 5;
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;

  // Vector types
  typedef logic [XLEN         -1:0] data_t;
  typedef logic [PLEN         -1:0] addr_t;
  typedef logic [XLEN/8       -1:0] be_t;
  typedef logic [BLK_BITS     -1:0] line_t;
  typedef logic [IDX_BITS     -1:0] idx_t;
  typedef logic [TAG_BITS     -1:0] tag_t;
  typedef logic [DAT_OFFS_BITS-1:0] offs_t;
  typedef logic [WAYS         -1:0] ways_t;

  ////////////////////////////////////////////////////////////
  // Grouped signals
  ////////////////////////////////////////////////////////////

  // Core request
  typedef struct packed {
    addr_t adr;
    logic  we;
    be_t   be;
    data_t d;
    logic  cacheable;
  } core_req_t;

  // Tag/data memory result for the presented address
  typedef struct packed {
    logic  hit;
    ways_t ways_hit;
    line_t line;
    logic  way_dirty;
    // Tag of the way picked for replacement
    tag_t  vtag;
  } lookup_t;

  // One pending store towards the data memory
  typedef struct packed {
    idx_t  idx;
    offs_t offs;
    data_t d;
    be_t   be;
    ways_t ways_hit;
  } wb_entry_t;

  // Dirty line waiting for write-back
  typedef struct packed {
    addr_t adr;
    line_t line;
  } evict_t;

  // Bus interface response
  typedef struct packed {
    data_t q;
    logic  ack;
    logic  stb_ack;
    logic  cmd_ack;
    logic  busy;
    addr_t adro;
    logic  nc_ack;
  } biu_rsp_t;

  // Bus interface command
  typedef enum logic [1:0] {
    NOP,
    READWAY,
    WRITEWAY
  } biucmd_e;

endpackage

`default_nettype wire

// File: source/dcache_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_read_mux (
  input  wire                   clk_i,

  input  dcache_pkg::core_req_t core_req_i,
  input  dcache_pkg::lookup_t   lookup_i,
  input  dcache_pkg::biu_rsp_t  biu_rsp_i,
  input  wire                   fill_pending_i,

  output dcache_pkg::data_t     q_o
);

  dcache_pkg::offs_t dat_offset;
  dcache_pkg::line_t line_shifted;
  dcache_pkg::data_t cache_q;
  logic              use_cache;

  ////////////////////////////////////////////////////////////
  // Word select from the line
  ////////////////////////////////////////////////////////////

  // Word position inside the block
  assign dat_offset = core_req_i.adr[dcache_pkg::BLK_OFFS_BITS-1 -: dcache_pkg::DAT_OFFS_BITS];

  // Move the addressed word down to bit 0
  assign line_shifted = lookup_i.line >> (dat_offset * dcache_pkg::XLEN);

  // Low word is the one asked for
  assign cache_q = line_shifted[dcache_pkg::XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////

  // During a fill the line only counts when it hits,
  // otherwise the word comes from the bus beat;
  // outside a fill uncached data always comes from the bus
  always_comb
  begin
    if (fill_pending_i)
      use_cache = lookup_i.hit;
    else
      use_cache = core_req_i.cacheable;
  end

  // Registered read data, lines up with ack
  always_ff @(posedge clk_i)
  begin
    if (use_cache)
      q_o <= cache_q;
    else
      q_o <= biu_rsp_i.q;
  end

endmodule

`default_nettype wire

// File: source/dcache_write_capture.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_write_capture (
  input  wire                   clk_i,
  input  wire                   rst_ni,

  input  wire                   wreq_i,
  input  wire                   flush_i,
  input  dcache_pkg::core_req_t core_req_i,
  input  dcache_pkg::lookup_t   lookup_i,
  input  wire                   writebuffer_ack_i,

  output logic                  wb_valid_o,
  output dcache_pkg::wb_entry_t wb_entry_o
);

  logic wr_hit;
  logic load;

  // Cacheable store that hits in one of the ways
  assign wr_hit = wreq_i & core_req_i.we & core_req_i.cacheable & lookup_i.hit;

  // Slot is free, or being freed this cycle
  assign load = wr_hit & ~flush_i & (~wb_valid_o | writebuffer_ack_i);

  ////////////////////////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      wb_valid_o <= 1'b0;
    else if (flush_i)
      wb_valid_o <= 1'b0;
    else if (load)
      wb_valid_o <= 1'b1;
    else if (writebuffer_ack_i)
      wb_valid_o <= 1'b0;
  end

  // Entry payload
  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      wb_entry_o.idx      <= core_req_i.adr[dcache_pkg::BLK_OFFS_BITS +: dcache_pkg::IDX_BITS];
      wb_entry_o.offs     <= core_req_i.adr[dcache_pkg::BLK_OFFS_BITS-1 -:
                                            dcache_pkg::DAT_OFFS_BITS];
      wb_entry_o.d        <= core_req_i.d;
      wb_entry_o.be       <= core_req_i.be;
      wb_entry_o.ways_hit <= lookup_i.ways_hit;
    end
  end

  // Data memory sees a steady entry until it acknowledges
  a_entry_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_valid_o && !writebuffer_ack_i |=> $stable(wb_entry_o)
  );

endmodule

`default_nettype wire

// File: sources.f
+incdir+tests
source/dcache_pkg.sv
source/dcache_miss_ctrl.sv
source/dcache_write_capture.sv
source/dcache_read_mux.sv
source/dcache_hit_top.sv
tests/tb_clock_gen.sv
tests/tb_dcache_hit.sv

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset held low for the first cycles
  initial
  begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/tb_dcache_tasks.svh
////////////////////////////////////////////////////////////
// Checks and waits
////////////////////////////////////////////////////////////

// End of a failing run
task automatic abort_run();
  $display("Simulation FAILED");
  $fatal(1, "stopped at first error");
endtask

// Compare and stop on the first mismatch
task automatic check_value(input string what, input wide_t expected, input wide_t actual);
  if (expected !== actual)
  begin
    $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    abort_run();
  end
endtask

task automatic wait_reset_release(input int max_cycles);
  int n;
  n = 0;
  while (rst_n !== 1'b1)
  begin
    if (n >= max_cycles)
    begin
      $display("Timeout: reset was never released");
      abort_run();
    end
    else
    begin
      @(posedge clk);
      n++;
    end
  end
endtask

// Polls at the falling edge
task automatic wait_armed(input int max_cycles);
  int n;
  n = 0;
  @(negedge clk);
  while (armed !== 1'b1)
  begin
    if (n >= max_cycles)
    begin
      $display("Timeout in %s: FSM never returned to armed", test_name);
      abort_run();
    end
    else
    begin
      @(negedge clk);
      n++;
    end
  end
endtask

task automatic wait_biucmd(input dcache_pkg::biucmd_e expected, input int max_cycles);
  int n;
  n = 0;
  @(negedge clk);
  while (biucmd !== expected)
  begin
    if (n >= max_cycles)
    begin
      $display("Timeout in %s: bus command %s never issued", test_name, expected.name());
      abort_run();
    end
    else
    begin
      @(negedge clk);
      n++;
    end
  end
endtask

////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////

// Quiet core, memories and bus
task automatic drive_idle();
  req          <= 1'b0;
  wreq         <= 1'b0;
  flush        <= 1'b0;
  core_req     <= '0;
  lookup       <= '0;
  wb_ack       <= 1'b0;
  biu_rsp      <= '0;
  inflight_cnt <= '0;
endtask

task automatic idle_cycles(input int n);
  repeat (n)
  begin
    @(posedge clk);
    drive_idle();
  end
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic test_reset_state();
  test_name = "reset_state";
  @(negedge clk);
  check_value("armed_o", wide_t'(1'b1), wide_t'(armed));
  check_value("filling_o", wide_t'(1'b0), wide_t'(filling));
  check_value("ack_o", wide_t'(1'b0), wide_t'(ack));
  check_value("wb_valid_o", wide_t'(1'b0), wide_t'(wb_valid));
  check_value("biucmd_o", wide_t'(dcache_pkg::NOP), wide_t'(biucmd));
endtask

task automatic test_read_hit();
  dcache_pkg::core_req_t r;
  dcache_pkg::lookup_t   lk;
  dcache_pkg::offs_t     offs;
  dcache_pkg::data_t     exp_q;
  test_name = "read_hit";
  r         = make_req(1'b0, 1'b1);
  lk        = make_lookup(1'b1, 1'b0);
  // Word 0 sits in the low bits of the line
  offs      = r.adr[3:2];
  exp_q     = lk.line[offs*dcache_pkg::XLEN +: dcache_pkg::XLEN];
  @(posedge clk);
  req      <= 1'b1;
  core_req <= r;
  lookup   <= lk;
  @(negedge clk);
  check_value("stall_o", wide_t'(1'b0), wide_t'(stall));
  check_value("idx_o", wide_t'(r.adr[8:4]), wide_t'(idx));
  check_value("core_tag_o", wide_t'(r.adr[31:9]), wide_t'(core_tag));
  @(posedge clk);
  req <= 1'b0;
  @(negedge clk);
  check_value("ack_o", wide_t'(1'b1), wide_t'(ack));
  check_value("q_o", wide_t'(exp_q), wide_t'(q));
  // Single cycle acknowledge
  @(negedge clk);
  check_value("ack_o low", wide_t'(1'b0), wide_t'(ack));
endtask

task automatic test_write_hit();
  dcache_pkg::core_req_t r;
  dcache_pkg::lookup_t   lk;
  dcache_pkg::wb_entry_t exp_entry;
  test_name          = "write_hit";
  r                  = make_req(1'b1, 1'b1);
  lk                 = make_lookup(1'b1, 1'b0);
  exp_entry.idx      = r.adr[8:4];
  exp_entry.offs     = r.adr[3:2];
  exp_entry.d        = r.d;
  exp_entry.be       = r.be;
  exp_entry.ways_hit = lk.ways_hit;
  @(posedge clk);
  req      <= 1'b1;
  wreq     <= 1'b1;
  core_req <= r;
  lookup   <= lk;
  @(negedge clk);
  check_value("stall_o", wide_t'(1'b0), wide_t'(stall));
  @(posedge clk);
  req    <= 1'b0;
  wreq   <= 1'b0;
  lookup <= make_lookup(1'b0, 1'b0);
  @(negedge clk);
  check_value("ack_o", wide_t'(1'b1), wide_t'(ack));
  check_value("wb_valid_o", wide_t'(1'b1), wide_t'(wb_valid));
  check_value("wb_entry_o", wide_t'(exp_entry), wide_t'(wb_entry));
  // Second store hits while the entry waits for the data memory
  r  = make_req(1'b1, 1'b1);
  lk = make_lookup(1'b1, 1'b0);
  @(posedge clk);
  req      <= 1'b1;
  wreq     <= 1'b1;
  core_req <= r;
  lookup   <= lk;
  // Entry held while the data memory is silent
  repeat (3)
  begin
    @(negedge clk);
    check_value("wb_valid_o held", wide_t'(1'b1), wide_t'(wb_valid));
    check_value("wb_entry_o held", wide_t'(exp_entry), wide_t'(wb_entry));
  end
  @(posedge clk);
  req    <= 1'b0;
  wreq   <= 1'b0;
  wb_ack <= 1'b1;
  @(posedge clk);
  wb_ack <= 1'b0;
  @(negedge clk);
  check_value("wb_valid_o after ack", wide_t'(1'b0), wide_t'(wb_valid));
  // Flushed write hit is dropped
  r  = make_req(1'b1, 1'b1);
  lk = make_lookup(1'b1, 1'b0);
  @(posedge clk);
  req      <= 1'b1;
  wreq     <= 1'b1;
  flush    <= 1'b1;
  core_req <= r;
  lookup   <= lk;
  @(posedge clk);
  req   <= 1'b0;
  wreq  <= 1'b0;
  flush <= 1'b0;
  @(negedge clk);
  check_value("wb_valid_o on flush", wide_t'(1'b0), wide_t'(wb_valid));
  check_value("ack_o on flush", wide_t'(1'b0), wide_t'(ack));
endtask

task automatic test_clean_miss();
  dcache_pkg::core_req_t r;
  dcache_pkg::data_t     bus_q;
  logic [127:0]          b;
  test_name = "clean_miss";
  r         = make_req(1'b0, 1'b1);
  b         = rand_bits(32);
  bus_q     = b[31:0];
  @(posedge clk);
  req      <= 1'b1;
  core_req <= r;
  lookup   <= make_lookup(1'b0, 1'b0);
  @(negedge clk);
  check_value("stall_o", wide_t'(1'b1), wide_t'(stall));
  check_value("biucmd_o idle", wide_t'(dcache_pkg::NOP), wide_t'(biucmd));
  @(negedge clk);
  check_value("biucmd_o fill", wide_t'(dcache_pkg::READWAY), wide_t'(biucmd));
  check_value("filling_o", wide_t'(1'b1), wide_t'(filling));
  check_value("armed_o", wide_t'(1'b0), wide_t'(armed));
  check_value("stall_o waiting", wide_t'(1'b1), wide_t'(stall));
  // Beat carrying the requested word
  @(posedge clk);
  biu_rsp.ack  <= 1'b1;
  biu_rsp.adro <= r.adr;
  biu_rsp.q    <= bus_q;
  @(negedge clk);
  check_value("stall_o on beat", wide_t'(1'b0), wide_t'(stall));
  @(posedge clk);
  req         <= 1'b0;
  biu_rsp.ack <= 1'b0;
  @(negedge clk);
  check_value("ack_o", wide_t'(1'b1), wide_t'(ack));
  check_value("q_o", wide_t'(bus_q), wide_t'(q));
  @(posedge clk);
  biu_rsp.cmd_ack <= 1'b1;
  @(posedge clk);
  biu_rsp.cmd_ack <= 1'b0;
  @(negedge clk);
  check_value("biucmd_o done", wide_t'(dcache_pkg::NOP), wide_t'(biucmd));
  check_value("filling_o done", wide_t'(1'b0), wide_t'(filling));
  wait_armed(10);
endtask

task automatic test_dirty_miss();
  dcache_pkg::core_req_t r;
  dcache_pkg::lookup_t   lk;
  dcache_pkg::evict_t    exp_ev;
  test_name   = "dirty_miss";
  r           = make_req(1'b0, 1'b1);
  lk          = make_lookup(1'b0, 1'b1);
  // Victim tag, set index, block aligned
  exp_ev.adr  = {lk.vtag, r.adr[8:4], 4'b0000};
  exp_ev.line = lk.line;
  @(posedge clk);
  req      <= 1'b1;
  core_req <= r;
  lookup   <= lk;
  @(negedge clk);
  check_value("stall_o", wide_t'(1'b1), wide_t'(stall));
  @(posedge clk);
  req    <= 1'b0;
  lookup <= make_lookup(1'b0, 1'b0);
  @(negedge clk);
  check_value("biucmd_o fill", wide_t'(dcache_pkg::READWAY), wide_t'(biucmd));
  check_value("filling_o", wide_t'(1'b1), wide_t'(filling));
  check_value("evict_o", wide_t'(exp_ev), wide_t'(evict));
  @(negedge clk);
  check_value("evict_o held", wide_t'(exp_ev), wide_t'(evict));
  @(posedge clk);
  biu_rsp.cmd_ack <= 1'b1;
  @(posedge clk);
  biu_rsp.cmd_ack <= 1'b0;
  @(negedge clk);
  check_value("biucmd_o write-back", wide_t'(dcache_pkg::WRITEWAY), wide_t'(biucmd));
  check_value("filling_o done", wide_t'(1'b0), wide_t'(filling));
  @(negedge clk);
  check_value("biucmd_o done", wide_t'(dcache_pkg::NOP), wide_t'(biucmd));
  wait_armed(10);
endtask

task automatic test_noncacheable();
  dcache_pkg::core_req_t r;
  dcache_pkg::data_t     bus_q;
  logic [127:0]          b;
  test_name = "noncacheable";
  r         = make_req(1'b0, 1'b0);
  b         = rand_bits(32);
  bus_q     = b[31:0];
  @(posedge clk);
  req      <= 1'b1;
  core_req <= r;
  lookup   <= make_lookup(1'b0, 1'b0);
  @(negedge clk);
  check_value("nc_req_o", wide_t'(1'b1), wide_t'(nc_req));
  check_value("stall_o", wide_t'(1'b1), wide_t'(stall));
  @(negedge clk);
  check_value("armed_o", wide_t'(1'b0), wide_t'(armed));
  // Request line only follows the core while armed
  check_value("nc_req_o after armed", wide_t'(1'b0), wide_t'(nc_req));
  check_value("stall_o no strobe", wide_t'(1'b1), wide_t'(stall));
  @(posedge clk);
  biu_rsp.stb_ack <= 1'b1;
  @(negedge clk);
  check_value("stall_o on strobe", wide_t'(1'b0), wide_t'(stall));
  @(posedge clk);
  req             <= 1'b0;
  biu_rsp.stb_ack <= 1'b0;
  inflight_cnt    <= INFLIGHT_BITS'(1);
  @(negedge clk);
  check_value("stall_o in flight", wide_t'(1'b1), wide_t'(stall));
  // Last beat comes back
  @(posedge clk);
  biu_rsp.ack    <= 1'b1;
  biu_rsp.nc_ack <= 1'b1;
  biu_rsp.adro   <= r.adr;
  biu_rsp.q      <= bus_q;
  @(posedge clk);
  biu_rsp.ack    <= 1'b0;
  biu_rsp.nc_ack <= 1'b0;
  inflight_cnt   <= '0;
  @(negedge clk);
  check_value("ack_o", wide_t'(1'b1), wide_t'(ack));
  check_value("q_o", wide_t'(bus_q), wide_t'(q));
  wait_armed(10);
endtask

task automatic test_busy_bus();
  test_name = "busy_bus";
  @(posedge clk);
  req          <= 1'b1;
  core_req     <= make_req(1'b0, 1'b1);
  lookup       <= make_lookup(1'b0, 1'b0);
  biu_rsp.busy <= 1'b1;
  repeat (3)
  begin
    @(negedge clk);
    check_value("stall_o", wide_t'(1'b1), wide_t'(stall));
    check_value("biucmd_o", wide_t'(dcache_pkg::NOP), wide_t'(biucmd));
    check_value("armed_o", wide_t'(1'b1), wide_t'(armed));
  end
  @(posedge clk);
  biu_rsp.busy <= 1'b0;
  wait_biucmd(dcache_pkg::READWAY, 10);
  check_value("filling_o", wide_t'(1'b1), wide_t'(filling));
  // Close the fill
  @(posedge clk);
  req             <= 1'b0;
  biu_rsp.cmd_ack <= 1'b1;
  @(posedge clk);
  biu_rsp.cmd_ack <= 1'b0;
  wait_armed(10);
  check_value("biucmd_o done", wide_t'(dcache_pkg::NOP), wide_t'(biucmd));
endtask

// File: tests/tb_dcache_hit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_hit;

  localparam int INFLIGHT_DEPTH = 2;
  localparam int INFLIGHT_BITS  = $clog2(INFLIGHT_DEPTH+1);
  // Stimulus LFSR start value
  localparam logic [15:0] LFSR_SEED = 16'd54531;

  // Wide enough for any compared value
  typedef logic [255:0] wide_t;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                      req;
  logic                      wreq;
  logic                      flush;
  dcache_pkg::core_req_t     core_req;
  dcache_pkg::lookup_t       lookup;
  logic                      wb_ack;
  dcache_pkg::biu_rsp_t      biu_rsp;
  logic [INFLIGHT_BITS -1:0] inflight_cnt;

  // DUT outputs
  logic                      stall;
  logic                      ack;
  dcache_pkg::data_t         q;
  logic                      armed;
  logic                      filling;
  dcache_pkg::idx_t          idx;
  dcache_pkg::tag_t          core_tag;
  logic                      wb_valid;
  dcache_pkg::wb_entry_t     wb_entry;
  dcache_pkg::evict_t        evict;
  dcache_pkg::biucmd_e       biucmd;
  logic                      nc_req;

  string       test_name;
  logic [15:0] lfsr_state;

  tb_clock_gen clock_gen0 (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dcache_hit_top #(
    .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
  ) dut0 (
    .clk_i                     (clk),
    .rst_ni                    (rst_n),
    .req_i                     (req),
    .wreq_i                    (wreq),
    .flush_i                   (flush),
    .core_req_i                (core_req),
    .stall_o                   (stall),
    .ack_o                     (ack),
    .q_o                       (q),
    .armed_o                   (armed),
    .filling_o                 (filling),
    .lookup_i                  (lookup),
    .idx_o                     (idx),
    .core_tag_o                (core_tag),
    .wb_valid_o                (wb_valid),
    .wb_entry_o                (wb_entry),
    .writebuffer_ack_i         (wb_ack),
    .evict_o                   (evict),
    .biu_rsp_i                 (biu_rsp),
    .inflight_cnt_i            (inflight_cnt),
    .biucmd_o                  (biucmd),
    .biucmd_noncacheable_req_o (nc_req)
  );

  ////////////////////////////////////////////////////////////
  // Random stimulus
  ////////////////////////////////////////////////////////////

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    else
      return s >> 1;
  endfunction

  // One LFSR step per bit, newest bit lands in bit 0
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    int           i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v          = {v[126:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Random core request
  function automatic dcache_pkg::core_req_t make_req(input logic we, input logic cacheable);
    dcache_pkg::core_req_t r;
    logic [127:0]          b;
    b           = rand_bits(32);
    r.adr       = b[31:0];
    r.we        = we;
    b           = rand_bits(4);
    r.be        = b[3:0];
    b           = rand_bits(32);
    r.d         = b[31:0];
    r.cacheable = cacheable;
    return r;
  endfunction

  // Random lookup result, one-hot way on a hit
  function automatic dcache_pkg::lookup_t make_lookup(input logic hit, input logic dirty);
    dcache_pkg::lookup_t lk;
    logic [127:0]        b;
    b            = rand_bits(1);
    lk.hit       = hit;
    lk.ways_hit  = hit ? (b[0] ? 2'b10 : 2'b01) : 2'b00;
    lk.line      = rand_bits(128);
    lk.way_dirty = dirty;
    b            = rand_bits(dcache_pkg::TAG_BITS);
    lk.vtag      = b[dcache_pkg::TAG_BITS-1:0];
    return lk;
  endfunction

  `include "tb_dcache_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    lfsr_state = LFSR_SEED;
    test_name  = "init";
    drive_idle();
    wait_reset_release(20);
    test_reset_state();
    test_read_hit();
    idle_cycles(2);
    test_write_hit();
    idle_cycles(2);
    test_clean_miss();
    idle_cycles(2);
    test_dirty_miss();
    idle_cycles(2);
    test_noncacheable();
    idle_cycles(2);
    test_busy_bus();
    idle_cycles(2);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
